//--- vc_alloc_pkg.sv
/*
 * virtual-channel allocator shared definitions
 * router dimensions, vector types and request/grant bundles
 */
package vc_alloc_pkg;

   // ------------------------------------------------------------------------
   // router dimensions
   // ------------------------------------------------------------------------

   localparam int num_ports = 5;
   localparam int num_message_classes = 2;
   localparam int num_resource_classes = 2;
   localparam int num_vcs_per_class = 2;

   // VCs inside one message class
   localparam int num_class_vcs = num_resource_classes * num_vcs_per_class;

   // VCs per port, ordered message class, resource class, VC in class
   localparam int num_vcs = num_message_classes * num_class_vcs;

   // ------------------------------------------------------------------------
   // vector types
   // ------------------------------------------------------------------------

   // one-hot port route or input port select
   typedef logic [num_ports-1:0] port_vec_t;

   // one bit per VC of a port
   typedef logic [num_vcs-1:0] vc_vec_t;

   // one-hot next resource class
   typedef logic [num_resource_classes-1:0] rc_vec_t;

   // stage-to-stage request and grant vectors within a message class
   typedef logic [num_class_vcs-1:0] class_vc_vec_t;

   // ------------------------------------------------------------------------
   // request and grant bundles
   // ------------------------------------------------------------------------

   // input VC request toward the allocator
   typedef struct packed {
      logic      req;
      port_vec_t route_op;
      rc_vec_t   route_orc;
   } vc_req_t;

   // allocation result back to the input controller
   typedef struct packed {
      logic    gnt;
      vc_vec_t sel_ovc;
   } vc_gnt_t;

   // allocation result to the output controller
   typedef struct packed {
      logic      gnt;
      port_vec_t sel_ip;
      vc_vec_t   sel_ivc;
   } ovc_ctl_t;

endpackage

//--- rr_arbiter.sv
/*
 * round-robin arbiter
 * grants the first requester at or after a pointer that moves on update
 */
`timescale 1ns/1ps

module rr_arbiter #(
   parameter int num_req = 4
) (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               update,
   input  logic [num_req-1:0] req,
   output logic [num_req-1:0] gnt
);

   localparam int ptr_w = (num_req > 1) ? $clog2(num_req) : 1;

   logic [ptr_w-1:0] ptr;
   logic [ptr_w-1:0] gnt_idx;
   logic             gnt_found;

   // search upward from the pointer, wrapping past the top
   always_comb
   begin : search
      int idx;
      gnt       = '0;
      gnt_idx   = '0;
      gnt_found = 1'b0;
      for (int i = 0; i < num_req; i++)
      begin
         idx = int'(ptr) + i;
         if (idx >= num_req)
         begin
            idx = idx - num_req;
         end
         if (req[idx] && !gnt_found)
         begin
            gnt[idx]  = 1'b1;
            gnt_idx   = ptr_w'(idx);
            gnt_found = 1'b1;
         end
      end
   end

   // winner drops to lowest priority
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         ptr <= '0;
      end
      else if (update && gnt_found)
      begin
         if (int'(gnt_idx) == num_req - 1)
         begin
            ptr <= '0;
         end
         else
         begin
            ptr <= gnt_idx + 1'b1;
         end
      end
   end

endmodule

//--- vc_alloc_input_stage.sv
/*
 * VC allocator input stage for one input VC
 * picks a candidate output VC per resource class and requests it
 */
`timescale 1ns/1ps

module vc_alloc_input_stage #(
   parameter int msg_class = 0,
   parameter int in_rc     = 0
) (
   input  logic                        clk,
   input  logic                        arst_n,
   input  vc_alloc_pkg::vc_req_t       vc_req,
   input  vc_alloc_pkg::vc_vec_t       elig_ovc [vc_alloc_pkg::num_ports],
   output vc_alloc_pkg::class_vc_vec_t req_out [vc_alloc_pkg::num_ports],
   input  vc_alloc_pkg::class_vc_vec_t gnt_out [vc_alloc_pkg::num_ports],
   output vc_alloc_pkg::vc_gnt_t       vc_gnt
);

   import vc_alloc_pkg::*;

   localparam int class_base = msg_class * num_class_vcs;

   rc_vec_t       route_orc;
   vc_vec_t       elig_sel;
   class_vc_vec_t elig_class;
   class_vc_vec_t pick;
   class_vc_vec_t gnt_or;

   // the last resource class can only stay where it is
   if (in_rc == num_resource_classes - 1)
   begin : g_last_rc
      assign route_orc = rc_vec_t'(1) << (num_resource_classes - 1);
   end
   else
   begin : g_route_rc
      assign route_orc = vc_req.route_orc;
   end

   // eligibility of the routed output port
   always_comb
   begin
      elig_sel = '0;
      for (int p = 0; p < num_ports; p++)
      begin
         if (vc_req.route_op[p])
         begin
            elig_sel = elig_sel | elig_ovc[p];
         end
      end
   end

   assign elig_class = elig_sel[class_base +: num_class_vcs];

   // ------------------------------------------------------------------------
   // per resource class candidate selection
   // ------------------------------------------------------------------------

   // arbitrate on eligibility alone, the request gates further down
   for (genvar orc = 0; orc < num_resource_classes; orc++)
   begin : g_orc
      logic [num_vcs_per_class-1:0] arb_gnt;

      rr_arbiter #(
         .num_req (num_vcs_per_class)
      ) arb_i (
         .clk    (clk),
         .arst_n (arst_n),
         .update (|gnt_or[orc*num_vcs_per_class +: num_vcs_per_class]),
         .req    (elig_class[orc*num_vcs_per_class +: num_vcs_per_class]),
         .gnt    (arb_gnt)
      );

      assign pick[orc*num_vcs_per_class +: num_vcs_per_class] =
         arb_gnt & {num_vcs_per_class{route_orc[orc]}};
   end

   // requests only toward the routed port
   always_comb
   begin
      gnt_or = '0;
      for (int p = 0; p < num_ports; p++)
      begin
         req_out[p] = (vc_req.req && vc_req.route_op[p]) ? pick : '0;
         // only the routed port can return a grant
         gnt_or     = gnt_or | gnt_out[p];
      end
   end

   always_comb
   begin
      vc_gnt.gnt     = |gnt_or;
      vc_gnt.sel_ovc = '0;
      vc_gnt.sel_ovc[class_base +: num_class_vcs] = gnt_or;
   end

endmodule

//--- vc_alloc_output_stage.sv
/*
 * VC allocator output stage for one output VC
 * picks an input VC on every input port, then the winning input port
 */
`timescale 1ns/1ps

module vc_alloc_output_stage #(
   parameter int msg_class = 0
) (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        elig,
   input  vc_alloc_pkg::class_vc_vec_t req_in [vc_alloc_pkg::num_ports],
   output vc_alloc_pkg::class_vc_vec_t gnt_in [vc_alloc_pkg::num_ports],
   output vc_alloc_pkg::ovc_ctl_t      ovc_ctl
);

   import vc_alloc_pkg::*;

   localparam int class_base = msg_class * num_class_vcs;

   port_vec_t     req_ip;
   port_vec_t     gnt_ip;
   class_vc_vec_t req_ivc [num_ports];
   class_vc_vec_t ivc_pick [num_ports];
   class_vc_vec_t ivc_or;

   // a busy output VC takes no requests
   always_comb
   begin
      for (int p = 0; p < num_ports; p++)
      begin
         req_ivc[p] = req_in[p] & {num_class_vcs{elig}};
         req_ip[p]  = |req_ivc[p];
      end
   end

   // ------------------------------------------------------------------------
   // input VC arbitration, one arbiter per input port
   // ------------------------------------------------------------------------

   for (genvar ip = 0; ip < num_ports; ip++)
   begin : g_ip
      // pointer moves only when this port wins the output VC
      rr_arbiter #(
         .num_req (num_class_vcs)
      ) ivc_arb_i (
         .clk    (clk),
         .arst_n (arst_n),
         .update (gnt_ip[ip]),
         .req    (req_ivc[ip]),
         .gnt    (ivc_pick[ip])
      );
   end

   // ------------------------------------------------------------------------
   // input port arbitration
   // ------------------------------------------------------------------------

   rr_arbiter #(
      .num_req (num_ports)
   ) ip_arb_i (
      .clk    (clk),
      .arst_n (arst_n),
      .update (|req_ip),
      .req    (req_ip),
      .gnt    (gnt_ip)
   );

   // only the winning port sees its pick granted
   always_comb
   begin
      ivc_or = '0;
      for (int p = 0; p < num_ports; p++)
      begin
         gnt_in[p] = gnt_ip[p] ? ivc_pick[p] : '0;
         ivc_or    = ivc_or | gnt_in[p];
      end
   end

   // control to the output controller, input VC placed at class offset
   always_comb
   begin
      ovc_ctl.gnt     = |req_ip;
      ovc_ctl.sel_ip  = gnt_ip;
      ovc_ctl.sel_ivc = '0;
      ovc_ctl.sel_ivc[class_base +: num_class_vcs] = ivc_or;
   end

endmodule

//--- vc_alloc_class.sv
/*
 * VC allocator slice for one message class
 * input and output stages joined by request and grant transposition
 */
`timescale 1ns/1ps

module vc_alloc_class #(
   parameter int msg_class = 0
) (
   input  logic clk,
   input  logic arst_n,
   input  vc_alloc_pkg::vc_req_t  vc_req [vc_alloc_pkg::num_ports][vc_alloc_pkg::num_vcs],
   input  vc_alloc_pkg::vc_vec_t  elig_ovc [vc_alloc_pkg::num_ports],
   output vc_alloc_pkg::vc_gnt_t  vc_gnt [vc_alloc_pkg::num_ports][vc_alloc_pkg::num_class_vcs],
   output vc_alloc_pkg::ovc_ctl_t ovc_ctl [vc_alloc_pkg::num_ports][vc_alloc_pkg::num_class_vcs]
);

   import vc_alloc_pkg::*;

   localparam int class_base = msg_class * num_class_vcs;

   // input-major [ip][ivc][op], one bit per output VC
   class_vc_vec_t req_ivc [num_ports][num_class_vcs][num_ports];
   class_vc_vec_t gnt_ivc [num_ports][num_class_vcs][num_ports];

   // output-major [op][ovc][ip], one bit per input VC
   class_vc_vec_t req_ovc [num_ports][num_class_vcs][num_ports];
   class_vc_vec_t gnt_ovc [num_ports][num_class_vcs][num_ports];

   // ------------------------------------------------------------------------
   // input stages
   // ------------------------------------------------------------------------

   for (genvar ip = 0; ip < num_ports; ip++)
   begin : g_ip
      for (genvar ivc = 0; ivc < num_class_vcs; ivc++)
      begin : g_ivc
         vc_alloc_input_stage #(
            .msg_class (msg_class),
            .in_rc     (ivc / num_vcs_per_class)
         ) in_i (
            .clk      (clk),
            .arst_n   (arst_n),
            .vc_req   (vc_req[ip][class_base + ivc]),
            .elig_ovc (elig_ovc),
            .req_out  (req_ivc[ip][ivc]),
            .gnt_out  (gnt_ivc[ip][ivc]),
            .vc_gnt   (vc_gnt[ip][ivc])
         );
      end
   end

   // requests into output-major order
   always_comb
   begin
      for (int ip = 0; ip < num_ports; ip++)
      begin
         for (int ivc = 0; ivc < num_class_vcs; ivc++)
         begin
            for (int op = 0; op < num_ports; op++)
            begin
               for (int ovc = 0; ovc < num_class_vcs; ovc++)
               begin
                  req_ovc[op][ovc][ip][ivc] = req_ivc[ip][ivc][op][ovc];
               end
            end
         end
      end
   end

   // grants back into input-major order
   always_comb
   begin
      for (int ip = 0; ip < num_ports; ip++)
      begin
         for (int ivc = 0; ivc < num_class_vcs; ivc++)
         begin
            for (int op = 0; op < num_ports; op++)
            begin
               for (int ovc = 0; ovc < num_class_vcs; ovc++)
               begin
                  gnt_ivc[ip][ivc][op][ovc] = gnt_ovc[op][ovc][ip][ivc];
               end
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   // output stages
   // ------------------------------------------------------------------------

   for (genvar op = 0; op < num_ports; op++)
   begin : g_op
      for (genvar ovc = 0; ovc < num_class_vcs; ovc++)
      begin : g_ovc
         vc_alloc_output_stage #(
            .msg_class (msg_class)
         ) out_i (
            .clk     (clk),
            .arst_n  (arst_n),
            .elig    (elig_ovc[op][class_base + ovc]),
            .req_in  (req_ovc[op][ovc]),
            .gnt_in  (gnt_ovc[op][ovc]),
            .ovc_ctl (ovc_ctl[op][ovc])
         );
      end
   end

endmodule

//--- vc_alloc_sep_if.sv
/*
 * separable input-first VC allocator
 * one allocator slice per message class, merged into per-port arrays
 */
`timescale 1ns/1ps

module vc_alloc_sep_if (
   input  logic clk,
   input  logic arst_n,
   input  vc_alloc_pkg::vc_req_t  vc_req [vc_alloc_pkg::num_ports][vc_alloc_pkg::num_vcs],
   input  vc_alloc_pkg::vc_vec_t  elig_ovc [vc_alloc_pkg::num_ports],
   output vc_alloc_pkg::vc_gnt_t  vc_gnt [vc_alloc_pkg::num_ports][vc_alloc_pkg::num_vcs],
   output vc_alloc_pkg::ovc_ctl_t ovc_ctl [vc_alloc_pkg::num_ports][vc_alloc_pkg::num_vcs]
);

   import vc_alloc_pkg::*;

   // message classes never share an output VC, so each slice is independent
   for (genvar mc = 0; mc < num_message_classes; mc++)
   begin : g_mc
      vc_gnt_t  class_gnt [num_ports][num_class_vcs];
      ovc_ctl_t class_ctl [num_ports][num_class_vcs];

      vc_alloc_class #(
         .msg_class (mc)
      ) class_i (
         .clk      (clk),
         .arst_n   (arst_n),
         .vc_req   (vc_req),
         .elig_ovc (elig_ovc),
         .vc_gnt   (class_gnt),
         .ovc_ctl  (class_ctl)
      );

      // place the slice at its message-class offset
      for (genvar p = 0; p < num_ports; p++)
      begin : g_port
         for (genvar v = 0; v < num_class_vcs; v++)
         begin : g_vc
            assign vc_gnt[p][mc*num_class_vcs + v]  = class_gnt[p][v];
            assign ovc_ctl[p][mc*num_class_vcs + v] = class_ctl[p][v];
         end
      end
   end

endmodule

//--- vc_alloc_properties.sv
/*
 * VC allocator grant properties
 * bound into the allocator top level
 */
`timescale 1ns/1ps

module vc_alloc_properties (
   input logic clk,
   input logic arst_n,
   input vc_alloc_pkg::vc_req_t  vc_req [vc_alloc_pkg::num_ports][vc_alloc_pkg::num_vcs],
   input vc_alloc_pkg::vc_vec_t  elig_ovc [vc_alloc_pkg::num_ports],
   input vc_alloc_pkg::vc_gnt_t  vc_gnt [vc_alloc_pkg::num_ports][vc_alloc_pkg::num_vcs],
   input vc_alloc_pkg::ovc_ctl_t ovc_ctl [vc_alloc_pkg::num_ports][vc_alloc_pkg::num_vcs]
);

   import vc_alloc_pkg::*;

   // input VCs holding each output VC, [op][ovc]
   int holders [num_ports][num_vcs];

   always_comb
   begin
      for (int op = 0; op < num_ports; op++)
      begin
         for (int w = 0; w < num_vcs; w++)
         begin
            holders[op][w] = 0;
            for (int ip = 0; ip < num_ports; ip++)
            begin
               for (int v = 0; v < num_vcs; v++)
               begin
                  if (vc_gnt[ip][v].gnt && vc_gnt[ip][v].sel_ovc[w]
                      && vc_req[ip][v].route_op[op])
                  begin
                     holders[op][w] = holders[op][w] + 1;
                  end
               end
            end
         end
      end
   end

   for (genvar p = 0; p < num_ports; p++)
   begin : g_port
      for (genvar v = 0; v < num_vcs; v++)
      begin : g_vc
         a_sel_ovc_onehot: assert property (@(posedge clk) disable iff (!arst_n)
            $onehot0(vc_gnt[p][v].sel_ovc))
            else $error("sel_ovc of input %0d VC %0d not one-hot", p, v);
         a_sel_ip_onehot: assert property (@(posedge clk) disable iff (!arst_n)
            $onehot0(ovc_ctl[p][v].sel_ip))
            else $error("sel_ip of output %0d VC %0d not one-hot", p, v);
         a_gnt_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
            vc_gnt[p][v].gnt |-> vc_req[p][v].req)
            else $error("grant without request on input %0d VC %0d", p, v);
         a_gnt_elig: assert property (@(posedge clk) disable iff (!arst_n)
            ovc_ctl[p][v].gnt |-> elig_ovc[p][v])
            else $error("busy output %0d VC %0d was granted", p, v);
         a_single_holder: assert property (@(posedge clk) disable iff (!arst_n)
            holders[p][v] <= 1)
            else $error("output %0d VC %0d granted to several input VCs", p, v);
      end
   end

endmodule

//--- tb_vc_alloc.sv
/*
 * VC allocator testbench
 * directed and random traffic checked against a pointer-level model
 */
`timescale 1ns/1ps

module tb_vc_alloc;

   import vc_alloc_pkg::*;

   localparam int clk_half = 4;
   localparam int wait_limit = 16;
   localparam vc_vec_t rc_mask = vc_vec_t'((1 << num_vcs_per_class) - 1);
   localparam vc_vec_t class_mask = vc_vec_t'((1 << num_class_vcs) - 1);

   logic     clk;
   logic     arst_n;
   vc_req_t  vc_req [num_ports][num_vcs];
   vc_vec_t  elig_ovc [num_ports];
   vc_gnt_t  vc_gnt [num_ports][num_vcs];
   ovc_ctl_t ovc_ctl [num_ports][num_vcs];

   // model pointers, indexed [ip][ivc][orc], [op][ovc][ip] and [op][ovc]
   int in_ptr [num_ports][num_vcs][num_resource_classes] = '{default: 0};
   int ivc_ptr [num_ports][num_vcs][num_ports] = '{default: 0};
   int ip_ptr [num_ports][num_vcs] = '{default: 0};
   int nxt_in_ptr [num_ports][num_vcs][num_resource_classes];
   int nxt_ivc_ptr [num_ports][num_vcs][num_ports];
   int nxt_ip_ptr [num_ports][num_vcs];
   vc_gnt_t  exp_gnt [num_ports][num_vcs];
   ovc_ctl_t exp_ctl [num_ports][num_vcs];

   int check_count = 0;
   int error_count = 0;
   int test_start = 0;

   vc_alloc_sep_if dut_i (
      .clk      (clk),
      .arst_n   (arst_n),
      .vc_req   (vc_req),
      .elig_ovc (elig_ovc),
      .vc_gnt   (vc_gnt),
      .ovc_ctl  (ovc_ctl)
   );

   bind vc_alloc_sep_if vc_alloc_properties props_i (.*);

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #clk_half clk = ~clk;
      end
   end

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      check_count++;
      if (got !== exp)
      begin
         error_count++;
         $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   // first requester at or after ptr, -1 when there is none
   function automatic int rr_first(input vc_vec_t req, input int n, input int ptr);
      int idx;
      int found;
      found = -1;
      for (int i = 0; i < n; i++)
      begin
         idx = (ptr + i) % n;
         if (req[idx] && found < 0)
         begin
            found = idx;
         end
      end
      return found;
   endfunction

   // ------------------------------------------------------------------------
   // reference model
   // ------------------------------------------------------------------------

   function automatic void predict_alloc();
      int            base;
      int            wp;
      int            wi;
      rc_vec_t       orc_vec;
      vc_vec_t       elig;
      port_vec_t     req_ip;
      class_vc_vec_t reqv [num_ports];
      class_vc_vec_t cand [num_ports][num_vcs];
      int            pick [num_ports][num_vcs][num_resource_classes];
      nxt_in_ptr  = in_ptr;
      nxt_ivc_ptr = ivc_ptr;
      nxt_ip_ptr  = ip_ptr;
      // input side, one candidate per resource class from the routed port
      for (int ip = 0; ip < num_ports; ip++)
      begin
         for (int v = 0; v < num_vcs; v++)
         begin
            base    = (v / num_class_vcs) * num_class_vcs;
            orc_vec = vc_req[ip][v].route_orc;
            if ((v % num_class_vcs) / num_vcs_per_class == num_resource_classes - 1)
            begin
               orc_vec = rc_vec_t'(1) << (num_resource_classes - 1);
            end
            elig = '0;
            for (int p = 0; p < num_ports; p++)
            begin
               if (vc_req[ip][v].route_op[p])
               begin
                  elig = elig | elig_ovc[p];
               end
            end
            cand[ip][v]    = '0;
            exp_gnt[ip][v] = '0;
            exp_ctl[ip][v] = '0;
            for (int orc = 0; orc < num_resource_classes; orc++)
            begin
               pick[ip][v][orc] = rr_first(elig >> (base + orc * num_vcs_per_class),
                                           num_vcs_per_class, in_ptr[ip][v][orc]);
               if (pick[ip][v][orc] >= 0 && orc_vec[orc] && vc_req[ip][v].req)
               begin
                  cand[ip][v][orc * num_vcs_per_class + pick[ip][v][orc]] = 1'b1;
               end
            end
         end
      end
      // output side, input VC per port first, then the port
      for (int op = 0; op < num_ports; op++)
      begin
         for (int w = 0; w < num_vcs; w++)
         begin
            base   = (w / num_class_vcs) * num_class_vcs;
            req_ip = '0;
            for (int ip = 0; ip < num_ports; ip++)
            begin
               for (int k = 0; k < num_class_vcs; k++)
               begin
                  reqv[ip][k] = cand[ip][base + k][w - base] && elig_ovc[op][w]
                                && vc_req[ip][base + k].route_op[op];
               end
               req_ip[ip] = |reqv[ip];
            end
            wp = rr_first(req_ip, num_ports, ip_ptr[op][w]);
            if (wp >= 0)
            begin
               wi = rr_first(reqv[wp], num_class_vcs, ivc_ptr[op][w][wp]);
               exp_ctl[op][w].gnt                = 1'b1;
               exp_ctl[op][w].sel_ip[wp]         = 1'b1;
               exp_ctl[op][w].sel_ivc[base + wi] = 1'b1;
               exp_gnt[wp][base + wi].gnt        = 1'b1;
               exp_gnt[wp][base + wi].sel_ovc[w] = 1'b1;
               nxt_ip_ptr[op][w]      = (wp + 1) % num_ports;
               nxt_ivc_ptr[op][w][wp] = (wi + 1) % num_class_vcs;
            end
         end
      end
      // input arbiter moves past its pick once its resource class is granted
      for (int ip = 0; ip < num_ports; ip++)
      begin
         for (int v = 0; v < num_vcs; v++)
         begin
            base = (v / num_class_vcs) * num_class_vcs;
            for (int orc = 0; orc < num_resource_classes; orc++)
            begin
               if (pick[ip][v][orc] >= 0 && ((exp_gnt[ip][v].sel_ovc
                   >> (base + orc * num_vcs_per_class)) & rc_mask) != '0)
               begin
                  nxt_in_ptr[ip][v][orc] = (pick[ip][v][orc] + 1) % num_vcs_per_class;
               end
            end
         end
      end
   endfunction

   // compare just before each rising edge, then advance the model
   initial
   begin
      forever
      begin
         @(negedge clk);
         #(clk_half - 1);
         if (arst_n)
         begin
            predict_alloc();
            for (int p = 0; p < num_ports; p++)
            begin
               for (int v = 0; v < num_vcs; v++)
               begin
                  check_value($sformatf("vc_gnt[%0d][%0d]", p, v), vc_gnt[p][v],
                              exp_gnt[p][v]);
                  check_value($sformatf("ovc_ctl[%0d][%0d]", p, v), ovc_ctl[p][v],
                              exp_ctl[p][v]);
               end
            end
            @(posedge clk);
            in_ptr  = nxt_in_ptr;
            ivc_ptr = nxt_ivc_ptr;
            ip_ptr  = nxt_ip_ptr;
         end
      end
   end

   // ------------------------------------------------------------------------
   // stimulus helpers
   // ------------------------------------------------------------------------

   task automatic clear_inputs();
      for (int p = 0; p < num_ports; p++)
      begin
         elig_ovc[p] = '1;
         for (int v = 0; v < num_vcs; v++)
         begin
            vc_req[p][v] = '0;
         end
      end
   endtask

   task automatic drive_request(input int ip, input int v, input int op, input int orc);
      vc_req[ip][v].req       = 1'b1;
      vc_req[ip][v].route_op  = port_vec_t'(1) << op;
      vc_req[ip][v].route_orc = rc_vec_t'(1) << orc;
   endtask

   task automatic wait_grant(input int ip, input int v);
      int cycles;
      bit seen;
      cycles = 0;
      seen   = 1'b0;
      #1;
      while (!seen && cycles < wait_limit)
      begin
         if (vc_gnt[ip][v].gnt)
         begin
            seen = 1'b1;
         end
         else
         begin
            @(negedge clk);
            #1;
            cycles++;
         end
      end
      if (!seen)
      begin
         error_count++;
         $display("Timeout: input port %0d VC %0d got no grant in %0d cycles",
                  ip, v, wait_limit);
      end
   endtask

   task automatic report_test(input int num, input string name);
      $display("test %0d %s done, %0d errors", num, name, error_count - test_start);
      test_start = error_count;
   endtask

   // ------------------------------------------------------------------------
   // tests
   // ------------------------------------------------------------------------

   task automatic single_request();
      @(negedge clk);
      clear_inputs();
      // VC 0 of class 0, resource class 0 is busy on port 2
      elig_ovc[2] = 8'b1111_1110;
      drive_request(0, 1, 2, 0);
      wait_grant(0, 1);
      check_value("vc_gnt[0][1].sel_ovc", vc_gnt[0][1].sel_ovc, 8'h02);
      check_value("ovc_ctl[2][1].sel_ip", ovc_ctl[2][1].sel_ip, 5'h01);
      check_value("ovc_ctl[2][1].sel_ivc", ovc_ctl[2][1].sel_ivc, 8'h02);
      @(negedge clk);
      clear_inputs();
      report_test(1, "single request");
   endtask

   task automatic busy_route();
      @(negedge clk);
      clear_inputs();
      elig_ovc[3] = 8'b1111_1100;
      drive_request(1, 0, 3, 0);
      repeat (4)
      begin
         #1;
         check_value("vc_gnt[1][0].gnt", vc_gnt[1][0].gnt, 1'b0);
         for (int w = 0; w < num_vcs; w++)
         begin
            check_value($sformatf("ovc_ctl[3][%0d].gnt", w), ovc_ctl[3][w].gnt, 1'b0);
         end
         @(negedge clk);
      end
      clear_inputs();
      report_test(2, "busy route");
   endtask

   task automatic last_class_route();
      @(negedge clk);
      clear_inputs();
      // class 1, last resource class, asking for resource class 0
      drive_request(4, 7, 0, 0);
      wait_grant(4, 7);
      check_value("vc_gnt[4][7].sel_ovc", vc_gnt[4][7].sel_ovc, 8'h40);
      check_value("ovc_ctl[0][6].sel_ip", ovc_ctl[0][6].sel_ip, 5'h10);
      check_value("ovc_ctl[0][6].sel_ivc", ovc_ctl[0][6].sel_ivc, 8'h80);
      @(negedge clk);
      clear_inputs();
      report_test(3, "last resource class");
   endtask

   task automatic contended_vc();
      int cont_ip [4] = '{0, 0, 2, 3};
      int cont_vc [4] = '{0, 1, 0, 1};
      int wins [4] = '{default: 0};
      int grants;
      @(negedge clk);
      clear_inputs();
      // on port 1 only VC 0 of resource class 0 is free
      elig_ovc[1] = 8'b1111_1101;
      for (int r = 0; r < 4; r++)
      begin
         drive_request(cont_ip[r], cont_vc[r], 1, 0);
      end
      for (int c = 0; c < 12; c++)
      begin
         #1;
         grants = 0;
         for (int r = 0; r < 4; r++)
         begin
            if (vc_gnt[cont_ip[r]][cont_vc[r]].gnt)
            begin
               grants++;
               wins[r]++;
            end
         end
         check_value("grant count", grants, 1);
         check_value("ovc_ctl[1][0].gnt", ovc_ctl[1][0].gnt, 1'b1);
         @(negedge clk);
      end
      for (int r = 0; r < 4; r++)
      begin
         if (wins[r] == 0)
         begin
            error_count++;
            $display("input port %0d VC %0d never won the contended VC", cont_ip[r],
                     cont_vc[r]);
         end
      end
      clear_inputs();
      report_test(4, "contention");
   endtask

   task automatic random_traffic();
      logic granted [num_ports][num_vcs] = '{default: 1'b0};
      vc_vec_t own_class;
      for (int c = 0; c < 300; c++)
      begin
         @(negedge clk);
         for (int p = 0; p < num_ports; p++)
         begin
            elig_ovc[p] = vc_vec_t'($urandom);
            for (int v = 0; v < num_vcs; v++)
            begin
               // a pending request is held until it is granted
               if (!vc_req[p][v].req || granted[p][v])
               begin
                  vc_req[p][v].req       = ($urandom % 3) == 0;
                  vc_req[p][v].route_op  = port_vec_t'(1) << ($urandom % num_ports);
                  vc_req[p][v].route_orc = rc_vec_t'(1) << ($urandom % num_resource_classes);
               end
            end
         end
         #1;
         for (int p = 0; p < num_ports; p++)
         begin
            for (int v = 0; v < num_vcs; v++)
            begin
               granted[p][v] = vc_gnt[p][v].gnt;
               own_class = class_mask << ((v / num_class_vcs) * num_class_vcs);
               check_value($sformatf("vc_gnt[%0d][%0d].sel_ovc other class", p, v),
                           vc_gnt[p][v].sel_ovc & ~own_class, '0);
            end
         end
      end
      @(negedge clk);
      clear_inputs();
      report_test(5, "random traffic");
   endtask

   initial
   begin
      void'($urandom(32'hf7de));
      arst_n = 1'b0;
      clear_inputs();
      repeat (5) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      single_request();
      busy_route();
      last_class_route();
      contended_vc();
      random_traffic();
      @(negedge clk);
      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0)
      begin
         $display("Regression passed");
      end
      else
      begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

//--- tb.f
vc_alloc_pkg.sv
rr_arbiter.sv
vc_alloc_input_stage.sv
vc_alloc_output_stage.sv
vc_alloc_class.sv
vc_alloc_sep_if.sv
vc_alloc_properties.sv
tb_vc_alloc.sv

//--- Bender.yml
package:
  name: vc_alloc

sources:
  - vc_alloc_pkg.sv
  - rr_arbiter.sv
  - vc_alloc_input_stage.sv
  - vc_alloc_output_stage.sv
  - vc_alloc_class.sv
  - vc_alloc_sep_if.sv
  - target: test
    files:
      - vc_alloc_properties.sv
      - tb_vc_alloc.sv
